// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f src.f --top-module rv_core_tb -o rv_core_sim
./obj_dir/rv_core_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"

// ==== source/execute.sv ====
// execute stage with operand select, ALU, branch compare and writeback select
`timescale 1ns/10ps
`default_nettype none

module execute import rv_core_pkg::*; (
    input  alu_op_e alu_op,
    input  src_a_e  src_a,
    input  src_b_e  src_b,
    input  branch_e branch,
    input  wb_sel_e wb_sel,
    input  xlen_t   rs1_data,
    input  xlen_t   rs2_data,
    input  xlen_t   imm,
    input  xlen_t   pc,
    output xlen_t   wb_data,
    output logic    branch_taken
);

    xlen_t op_a;
    xlen_t op_b;
    xlen_t alu_res;
    logic  rs_lt; // signed rs1 < rs2

    assign op_a = (src_a == src_a_pc) ? pc : rs1_data;
    assign op_b = (src_b == src_b_imm) ? imm : rs2_data;

    always_comb begin
        case (alu_op)
            alu_add:    alu_res = op_a + op_b;
            alu_sub:    alu_res = op_a - op_b;
            alu_and:    alu_res = op_a & op_b;
            alu_or:     alu_res = op_a | op_b;
            alu_xor:    alu_res = op_a ^ op_b;
            alu_slt:    alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_res = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_pass_b: alu_res = op_b;
        endcase
    end

    assign rs_lt = $signed(rs1_data) < $signed(rs2_data);

    always_comb begin
        case (branch)
            br_eq:   branch_taken = (rs1_data == rs2_data);
            br_ne:   branch_taken = (rs1_data != rs2_data);
            br_lt:   branch_taken = rs_lt;
            br_ge:   branch_taken = !rs_lt;
            default: branch_taken = 1'b0;
        endcase
    end

    // link address for jal and jalr
    assign wb_data = (wb_sel == wb_pc4) ? pc + xlen_t'(4) : alu_res;

endmodule

`default_nettype wire

// ==== source/imm_gen.sv ====
// immediate generator that sign-extends the I, S, B, U and J formats
`timescale 1ns/10ps
`default_nettype none

module imm_gen import rv_core_pkg::*; (
    input  inst_t    inst,
    input  imm_fmt_e imm_fmt,
    output xlen_t    imm
);

    always_comb begin
        case (imm_fmt)
            imm_i: imm = {{20{inst[31]}}, inst[31:20]};
            imm_s: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            imm_b: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            imm_u: imm = {inst[31:12], 12'b0};
            imm_j: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/inst_decoder.sv ====
// instruction decoder for the supported RV32I subset that flags anything else as unknown
`timescale 1ns/10ps
`default_nettype none

module inst_decoder import rv_core_pkg::*; (
    input  inst_t inst,
    output ctrl_t ctrl,
    output logic  unknown_code
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        // defaults describe a harmless no-op
        ctrl.reg_wen = 1'b0;
        ctrl.rd      = inst[11:7];
        ctrl.rs1     = inst[19:15];
        ctrl.rs2     = inst[24:20];
        ctrl.imm_fmt = imm_i;
        ctrl.alu_op  = alu_add;
        ctrl.src_a   = src_a_reg1;
        ctrl.src_b   = src_b_reg2;
        ctrl.branch  = br_none;
        ctrl.wb_sel  = wb_alu;
        ctrl.jump    = 1'b0;
        ctrl.jalr    = 1'b0;
        unknown_code = 1'b0;

        case (opcode)
            opc_op_imm: begin
                ctrl.reg_wen = 1'b1;
                ctrl.src_b   = src_b_imm;
                case (funct3)
                    3'b000: ctrl.alu_op = alu_add;
                    3'b010: ctrl.alu_op = alu_slt;
                    3'b011: ctrl.alu_op = alu_sltu;
                    3'b100: ctrl.alu_op = alu_xor;
                    3'b110: ctrl.alu_op = alu_or;
                    3'b111: ctrl.alu_op = alu_and;
                    default: unknown_code = 1'b1; // shifts not supported
                endcase
            end
            opc_op: begin
                ctrl.reg_wen = 1'b1;
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000: ctrl.alu_op = alu_add;
                        3'b010: ctrl.alu_op = alu_slt;
                        3'b011: ctrl.alu_op = alu_sltu;
                        3'b100: ctrl.alu_op = alu_xor;
                        3'b110: ctrl.alu_op = alu_or;
                        3'b111: ctrl.alu_op = alu_and;
                        default: unknown_code = 1'b1;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    ctrl.alu_op = alu_sub;
                end else begin
                    unknown_code = 1'b1;
                end
            end
            opc_lui: begin
                ctrl.reg_wen = 1'b1;
                ctrl.imm_fmt = imm_u;
                ctrl.src_b   = src_b_imm;
                ctrl.alu_op  = alu_pass_b;
            end
            opc_auipc: begin
                ctrl.reg_wen = 1'b1;
                ctrl.imm_fmt = imm_u;
                ctrl.src_a   = src_a_pc;
                ctrl.src_b   = src_b_imm;
            end
            opc_jal: begin
                ctrl.reg_wen = 1'b1;
                ctrl.imm_fmt = imm_j;
                ctrl.wb_sel  = wb_pc4;
                ctrl.jump    = 1'b1;
            end
            opc_jalr: begin
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel  = wb_pc4;
                ctrl.jalr    = 1'b1;
                unknown_code = (funct3 != 3'b000);
            end
            opc_branch: begin
                ctrl.imm_fmt = imm_b;
                case (funct3)
                    3'b000: ctrl.branch = br_eq;
                    3'b001: ctrl.branch = br_ne;
                    3'b100: ctrl.branch = br_lt;
                    3'b101: ctrl.branch = br_ge;
                    default: unknown_code = 1'b1; // unsigned compares left out
                endcase
            end
            default: unknown_code = 1'b1;
        endcase

        // an unknown word must not write or redirect
        if (unknown_code) begin
            ctrl.reg_wen = 1'b0;
            ctrl.jump    = 1'b0;
            ctrl.jalr    = 1'b0;
            ctrl.branch  = br_none;
        end
    end

endmodule

`default_nettype wire

// ==== source/pc_unit.sv ====
// program counter register with next-pc selection for branches and jumps
`timescale 1ns/10ps
`default_nettype none

module pc_unit import rv_core_pkg::*; #(
    parameter xlen_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  jump,
    input  logic  jalr,
    input  logic  branch_taken,
    input  xlen_t imm,
    input  xlen_t rs1_data,
    output xlen_t pc
);

    xlen_t next_pc;
    xlen_t jalr_target;

    assign jalr_target = rs1_data + imm;

    always_comb begin
        if (jalr) begin
            next_pc = {jalr_target[xlen-1:1], 1'b0}; // lsb cleared
        end else if (jump || branch_taken) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc + xlen_t'(4);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
// 32 x 32-bit register file with two async read ports and one write port where x0 reads as zero
`timescale 1ns/10ps
`default_nettype none

module reg_file import rv_core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wen,
    input  reg_addr_t waddr,
    input  xlen_t     wdata,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output xlen_t     rdata1,
    output xlen_t     rdata2
);

    localparam int num_regs = 2 ** $bits(reg_addr_t);

    xlen_t regs [num_regs];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin // x0 writes dropped
            regs[waddr] <= wdata;
        end
    end

    // combinational reads with x0 always zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== source/rv_core_pkg.sv ====
// shared package of the rv_core with data widths, control enums and the decoded-control struct
`default_nettype none

package rv_core_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] xlen_t;     // data, address and pc word
    typedef logic [31:0]     inst_t;     // raw instruction word
    typedef logic [4:0]      reg_addr_t; // register index

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_pass_b // lui result
    } alu_op_e;

    typedef enum logic {src_a_reg1, src_a_pc} src_a_e;
    typedef enum logic {src_b_reg2, src_b_imm} src_b_e;

    typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_fmt_e;

    typedef enum logic [2:0] {br_none, br_eq, br_ne, br_lt, br_ge} branch_e;

    typedef enum logic {wb_alu, wb_pc4} wb_sel_e;

    typedef struct packed {
        logic      reg_wen;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        imm_fmt_e  imm_fmt;
        alu_op_e   alu_op;
        src_a_e    src_a;
        src_b_e    src_b;
        branch_e   branch;
        wb_sel_e   wb_sel;
        logic      jump; // jal
        logic      jalr;
    } ctrl_t;

    // RV32I major opcodes
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

endpackage

`default_nettype wire

// ==== source/rv_core_top.sv ====
// single-cycle RV32I core top that wires decode, register file, execute and pc together
`timescale 1ns/10ps
`default_nettype none

module rv_core_top import rv_core_pkg::*; #(
    parameter xlen_t RESET_PC = '0
) (
    input  logic      clk,
    input  logic      rst_n,
    input  inst_t     inst,
    output xlen_t     pc,
    output logic      wb_en,
    output reg_addr_t wb_addr,
    output xlen_t     wb_data,
    output logic      unknown_code
);

    ctrl_t ctrl;         // decoded control
    xlen_t imm;
    xlen_t rs1_data;
    xlen_t rs2_data;
    logic  branch_taken;

    assign wb_en   = ctrl.reg_wen && !unknown_code && (ctrl.rd != '0);
    assign wb_addr = ctrl.rd;

    pc_unit #(
        .RESET_PC (RESET_PC)
    ) u_pc_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .jump         (ctrl.jump),
        .jalr         (ctrl.jalr),
        .branch_taken (branch_taken),
        .imm          (imm),
        .rs1_data     (rs1_data),
        .pc           (pc)
    );

    inst_decoder u_inst_decoder (
        .inst         (inst),
        .ctrl         (ctrl),
        .unknown_code (unknown_code)
    );

    imm_gen u_imm_gen (
        .inst    (inst),
        .imm_fmt (ctrl.imm_fmt),
        .imm     (imm)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .wen    (ctrl.reg_wen),
        .waddr  (ctrl.rd),
        .wdata  (wb_data),
        .raddr1 (ctrl.rs1),
        .raddr2 (ctrl.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    execute u_execute (
        .alu_op       (ctrl.alu_op),
        .src_a        (ctrl.src_a),
        .src_b        (ctrl.src_b),
        .branch       (ctrl.branch),
        .wb_sel       (ctrl.wb_sel),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .imm          (imm),
        .pc           (pc),
        .wb_data      (wb_data),
        .branch_taken (branch_taken)
    );

endmodule

`default_nettype wire

// ==== src.f ====
source/rv_core_pkg.sv
source/pc_unit.sv
source/inst_decoder.sv
source/imm_gen.sv
source/reg_file.sv
source/execute.sv
source/rv_core_top.sv
test/rv_core_tb.sv

// ==== test/rv_core_patterns.txt ====
// columns: inst, expected pc, flags (bit0 wb_en, bit1 unknown_code), wb_addr, wb_data
// RESET_PC is 0, wb_addr and wb_data are only checked when wb_en is expected
00500093 00000000 1 01 00000005
FFD00113 00000004 1 02 FFFFFFFD
123451B7 00000008 1 03 12345000
00001217 0000000C 1 04 0000100C
002082B3 00000010 1 05 00000002
40208333 00000014 1 06 00000008
0020F3B3 00000018 1 07 00000005
0020E433 0000001C 1 08 FFFFFFFD
0020C4B3 00000020 1 09 FFFFFFF8
00112533 00000024 1 0A 00000001
001135B3 00000028 1 0B 00000000
0FF0C613 0000002C 1 0C 000000FA
0F017693 00000030 1 0D 000000F0
7000E713 00000034 1 0E 00000705
FFF12793 00000038 1 0F 00000001
FFF0B813 0000003C 1 10 00000001
00108463 00000040 0 00 00000000
00109463 00000048 0 00 00000000
00114663 0000004C 0 00 00000000
00115463 00000058 0 00 00000000
FE20DCE3 0000005C 0 00 00000000
020008EF 00000054 1 11 00000058
02988967 00000074 1 12 00000078
00708013 00000080 0 00 00000000
001009B3 00000084 1 13 00000005
00000000 00000088 2 00 00000000
00109A33 0000008C 2 00 00000000
000A0AB3 00000090 1 15 00000000
0020E463 00000094 2 00 00000000

// ==== test/rv_core_tb.sv ====
// testbench for the single-cycle RV32I core that streams instruction patterns
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb import rv_core_pkg::*; ();

    localparam int num_patterns = 29;
    localparam int num_fields   = 5;  // inst, pc, flags, wb_addr, wb_data
    localparam int clk_period   = 4;

    logic      clk;
    logic      rst_n;
    inst_t     inst;
    xlen_t     pc;
    logic      wb_en;
    reg_addr_t wb_addr;
    xlen_t     wb_data;
    logic      unknown_code;

    logic [31:0] pattern_mem [num_patterns*num_fields];
    int          errors;

    rv_core_top #(
        .RESET_PC (32'h0)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst         (inst),
        .pc           (pc),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .unknown_code (unknown_code)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period/2) clk = ~clk;
    end

    // watchdog with a margin over reset plus one cycle per pattern
    initial begin
        #((num_patterns + 10) * clk_period);
        $display("timeout: the run did not finish within %0d clock cycles", num_patterns + 10);
        $display("Testbench failed");
        $finish;
    end

    task automatic report_mismatch(input int idx, input string name,
                                   input xlen_t got, input xlen_t exp);
        errors++;
        $display("FAILED t=%0t pattern %0d %s: got %h, expected %h",
                 $time, idx, name, got, exp);
    endtask

    task automatic check_pattern(input int idx);
        int        base;
        xlen_t     exp_pc;
        logic      exp_wen;
        logic      exp_unknown;
        reg_addr_t exp_addr;
        xlen_t     exp_data;
        base        = idx * num_fields;
        exp_pc      = pattern_mem[base+1];
        exp_wen     = pattern_mem[base+2][0]; // flag bit 0
        exp_unknown = pattern_mem[base+2][1]; // flag bit 1
        exp_addr    = reg_addr_t'(pattern_mem[base+3]);
        exp_data    = pattern_mem[base+4];
        assert (pc === exp_pc)
            else report_mismatch(idx, "pc", pc, exp_pc);
        assert (wb_en === exp_wen)
            else report_mismatch(idx, "wb_en", xlen_t'(wb_en), xlen_t'(exp_wen));
        assert (unknown_code === exp_unknown)
            else report_mismatch(idx, "unknown_code",
                                 xlen_t'(unknown_code), xlen_t'(exp_unknown));
        if (exp_wen) begin // writeback fields only meaningful on a write
            assert (wb_addr === exp_addr)
                else report_mismatch(idx, "wb_addr", xlen_t'(wb_addr), xlen_t'(exp_addr));
            assert (wb_data === exp_data)
                else report_mismatch(idx, "wb_data", wb_data, exp_data);
        end
    endtask

    initial begin
        errors = 0;
        rst_n  = 1'b0;
        inst   = '0;
        $readmemh("test/rv_core_patterns.txt", pattern_mem);
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < num_patterns; i++) begin
            inst = pattern_mem[i*num_fields]; // 1 ns after the edge
            #2;
            check_pattern(i); // 1 ns before the next edge
            @(posedge clk);
            #1;
        end
        $display("checks done: %0d errors over %0d patterns", errors, num_patterns);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
